// ==== design/spi_defines.svh ====
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths.
`define SPI_DATA_W 8 // one byte per transfer and per bus access.
`define SPI_ADDR_W 2
`define SPI_DIV_W 3 // prescaler select field.
`define SPI_CNT_W 4 // bit counters in the shift engine.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map.
`define SPI_ADDR_CTRL 2'd0
`define SPI_ADDR_STAT 2'd1
`define SPI_ADDR_DATA 2'd2 // write to send, read to receive.

// control bits, divider sits in bits 2..0.
`define SPI_CTRL_EN 7
`define SPI_CTRL_CPOL 6
`define SPI_CTRL_CPHA 5
`define SPI_CTRL_IE 4
`define SPI_CTRL_RSVD 3 // always reads zero.

// status bits, the rest read zero.
`define SPI_STAT_TXE 0
`define SPI_STAT_RXNE 1
`define SPI_STAT_BUSY 2

`endif

// ==== design/spi_pkg.sv ====
`include "spi_defines.svh"

package spi_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// vector types.
	typedef logic [`SPI_DATA_W-1:0] spi_data_t; // data byte and bus word.
	typedef logic [`SPI_ADDR_W-1:0] spi_addr_t;
	typedef logic [`SPI_DIV_W-1:0] spi_div_t; // half period is 2**(div+1) cycles.
	typedef logic [`SPI_CNT_W-1:0] spi_bit_cnt_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shift engine states.
	typedef enum logic [1:0] {
		st_idle, // no transfer.
		st_lead, // waiting for the leading sck edge.
		st_trail // waiting for the trailing sck edge.
	} spi_shift_state_t;

endpackage

// ==== design/spi_wb_regs.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_wb_regs (
	input logic sys,
	input logic n_sh_reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input spi_pkg::spi_addr_t wb_adr,
	input spi_pkg::spi_data_t wb_dat_w,
	output spi_pkg::spi_data_t wb_dat_r,
	output logic wb_ack,
	input logic tx_take,
	input logic rx_strobe,
	input spi_pkg::spi_data_t rx_byte,
	input logic busy,
	output logic tx_valid,
	output spi_pkg::spi_data_t tx_byte,
	output logic en,
	output logic cpol,
	output logic cpha,
	output spi_pkg::spi_div_t div,
	output logic interrupt
);
	import spi_pkg::*;

	spi_data_t ctrl;
	spi_data_t stat;
	spi_data_t tx_buf;
	spi_data_t rx_buf;
	spi_data_t rd_mux;
	logic access;
	logic wr;
	logic rd;
	logic wr_dat;
	logic rd_dat;
	logic txe;
	logic rxne;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus decode.
	assign access = wb_cyc & wb_stb & ~wb_ack; // no new access while acking.
	assign wr = access & wb_we;
	assign rd = access & ~wb_we;
	assign wr_dat = wr & (wb_adr == `SPI_ADDR_DATA);
	assign rd_dat = rd & (wb_adr == `SPI_ADDR_DATA);

	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;
	end

	always_comb begin
		stat = '0;
		stat[`SPI_STAT_TXE] = txe;
		stat[`SPI_STAT_RXNE] = rxne;
		stat[`SPI_STAT_BUSY] = busy;
	end

	always_comb begin
		case (wb_adr)
			`SPI_ADDR_CTRL: rd_mux = ctrl;
			`SPI_ADDR_STAT: rd_mux = stat;
			`SPI_ADDR_DATA: rd_mux = rx_buf;
			default: rd_mux = '0;
		endcase
	end

	// read data lands with the ack.
	always_ff @(posedge sys) begin
		if (rd)
			wb_dat_r <= rd_mux;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control and transmit side.
	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			ctrl <= '0;
		end else if (wr && wb_adr == `SPI_ADDR_CTRL) begin
			ctrl <= wb_dat_w;
			ctrl[`SPI_CTRL_RSVD] <= 1'b0;
		end
	end

	always_ff @(posedge sys) begin
		if (wr_dat)
			tx_buf <= wb_dat_w; // overwrites a byte still waiting.
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			txe <= 1'b1;
		else if (!en)
			txe <= 1'b1; // disabled core drops the waiting byte.
		else if (wr_dat)
			txe <= 1'b0; // new byte beats a take in the same cycle.
		else if (tx_take)
			txe <= 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive side and interrupt.
	always_ff @(posedge sys) begin
		if (rx_strobe)
			rx_buf <= rx_byte;
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			rxne <= 1'b0;
		else if (rx_strobe)
			rxne <= 1'b1; // arriving byte wins over the read.
		else if (rd_dat)
			rxne <= 1'b0;
	end

	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			interrupt <= 1'b0;
		else
			interrupt <= rxne & ctrl[`SPI_CTRL_IE];
	end

	assign tx_valid = ~txe;
	assign tx_byte = tx_buf;
	assign en = ctrl[`SPI_CTRL_EN];
	assign cpol = ctrl[`SPI_CTRL_CPOL];
	assign cpha = ctrl[`SPI_CTRL_CPHA];
	assign div = ctrl[`SPI_DIV_W-1:0];

	// a held strobe must see a gap before its next ack.
	ack_single: assert property (
		@(posedge sys) disable iff (!n_sh_reset)
		wb_ack |=> !wb_ack
	);

endmodule

// ==== design/spi_shifter.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_shifter (
	input logic sys,
	input logic n_sh_reset,
	input logic en,
	input logic cpha,
	input logic tx_valid,
	input spi_pkg::spi_data_t tx_byte,
	input logic lead_edge,
	input logic trail_edge,
	input logic miso_bit,
	output logic tx_take,
	output logic rx_strobe,
	output spi_pkg::spi_data_t rx_byte,
	output logic busy,
	output logic run,
	output logic mosi_bit,
	output logic ss_active
);
	import spi_pkg::*;

	localparam spi_bit_cnt_t LAST_BIT = spi_bit_cnt_t'(`SPI_DATA_W - 1);

	spi_shift_state_t state;
	spi_data_t tx_sh;
	spi_data_t rx_sh;
	spi_bit_cnt_t bit_cnt; // trailing edges seen in this transfer.
	spi_bit_cnt_t rx_cnt; // bits sampled into rx_sh.
	logic sample_edge;
	logic advance_edge;
	logic final_edge;
	logic load;
	logic smp_pend;
	logic mosi_q;

	assign run = (state != st_idle);
	assign ss_active = run;
	assign sample_edge = run & (cpha ? trail_edge : lead_edge);
	assign advance_edge = run & (cpha ? lead_edge : trail_edge);
	assign final_edge = (state == st_trail) & trail_edge & (bit_cnt == LAST_BIT);
	assign load = en & tx_valid & (~run | final_edge); // reload back to back.
	assign tx_take = load;
	assign busy = run | smp_pend | rx_strobe; // held until the byte is handed on.
	assign mosi_bit = mosi_q;
	assign rx_byte = rx_sh;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// edge sequencing.
	always_ff @(posedge sys) begin
		if (!n_sh_reset || !en) begin
			state <= st_idle;
			bit_cnt <= '0;
		end else if (load) begin
			state <= st_lead;
			bit_cnt <= '0;
		end else begin
			case (state)
				st_lead: if (lead_edge) state <= st_trail;
				st_trail: if (trail_edge) begin
					bit_cnt <= bit_cnt + 1'b1;
					state <= final_edge ? st_idle : st_lead;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// transmit, MSB first. mode 0/2 shows the first bit at load.
	always_ff @(posedge sys) begin
		if (!n_sh_reset)
			mosi_q <= 1'b0;
		else if (load)
			mosi_q <= tx_byte[`SPI_DATA_W-1];
		else if (advance_edge)
			mosi_q <= tx_sh[`SPI_DATA_W-1];
	end

	always_ff @(posedge sys) begin
		if (load)
			tx_sh <= cpha ? tx_byte : {tx_byte[`SPI_DATA_W-2:0], 1'b0};
		else if (advance_edge)
			tx_sh <= {tx_sh[`SPI_DATA_W-2:0], 1'b0};
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive. sample one cycle after the edge pulse,
	// which covers the sck register and the miso sync delay.
	always_ff @(posedge sys) begin
		if (!n_sh_reset || !en) begin
			smp_pend <= 1'b0;
			rx_cnt <= '0;
			rx_strobe <= 1'b0;
		end else begin
			smp_pend <= sample_edge;
			rx_strobe <= smp_pend & (rx_cnt == LAST_BIT);
			if (smp_pend)
				rx_cnt <= (rx_cnt == LAST_BIT) ? '0 : rx_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys) begin
		if (smp_pend)
			rx_sh <= {rx_sh[`SPI_DATA_W-2:0], miso_bit};
	end

	// a take always starts a fresh transfer in the next cycle.
	take_legal: assert property (
		@(posedge sys) disable iff (!n_sh_reset || !en)
		tx_take |-> (state == st_idle || final_edge) ##1 (state == st_lead)
	);

endmodule

// ==== design/spi_serial_port.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_serial_port (
	input logic sys,
	input logic n_sh_reset,
	input logic en,
	input logic cpol,
	input spi_pkg::spi_div_t div,
	input logic run,
	input logic mosi_bit,
	input logic ss_active,
	input logic miso,
	output logic lead_edge,
	output logic trail_edge,
	output logic miso_bit,
	output logic sck,
	output logic mosi,
	output logic ss_n
);

	localparam int PRE_W = 1 << `SPI_DIV_W; // covers the largest half period.

	logic [PRE_W-1:0] pre_cnt;
	logic [PRE_W-1:0] pre_mask;
	logic active;
	logic tick;
	logic phase; // high between leading and trailing edge.
	logic miso_meta;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// prescaler and edge pulses.
	assign active = en & run;
	assign pre_mask = {PRE_W{1'b1}} >> ((PRE_W - 1) - div); // 2**(div+1) - 1.
	assign tick = active & (pre_cnt == pre_mask);
	assign lead_edge = tick & ~phase;
	assign trail_edge = tick & phase;

	always_ff @(posedge sys) begin
		if (!n_sh_reset || !active) begin
			pre_cnt <= '0;
			phase <= 1'b0;
		end else begin
			pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
			if (tick)
				phase <= ~phase;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pins.
	always_ff @(posedge sys) begin
		if (!n_sh_reset) begin
			sck <= 1'b0;
			mosi <= 1'b0;
			ss_n <= 1'b1;
		end else begin
			sck <= cpol ^ (phase ^ tick); // idles at cpol.
			mosi <= mosi_bit;
			ss_n <= ~ss_active;
		end
	end

	// two-flop sync on miso.
	always_ff @(posedge sys) begin
		miso_meta <= miso;
		miso_bit <= miso_meta;
	end

	edges_apart: assert property (
		@(posedge sys) disable iff (!n_sh_reset)
		!(lead_edge && trail_edge)
	);

endmodule

// ==== design/spi_master.sv ====
`timescale 1ns/100ps

module spi_master (
	input logic sys,
	input logic n_sh_reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input spi_pkg::spi_addr_t wb_adr,
	input spi_pkg::spi_data_t wb_dat_w,
	output spi_pkg::spi_data_t wb_dat_r,
	output logic wb_ack,
	output logic interrupt,
	input logic miso,
	output logic sck,
	output logic mosi,
	output logic ss_n
);
	import spi_pkg::*;

	// register side to shifter.
	logic tx_valid;
	logic tx_take;
	logic rx_strobe;
	logic busy;
	spi_data_t tx_byte;
	spi_data_t rx_byte;

	// control fields.
	logic en;
	logic cpol;
	logic cpha;
	spi_div_t div;

	// shifter to pins.
	logic lead_edge;
	logic trail_edge;
	logic miso_bit;
	logic run;
	logic mosi_bit;
	logic ss_active;

	spi_wb_regs i_spi_wb_regs (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.tx_take(tx_take),
		.rx_strobe(rx_strobe),
		.rx_byte(rx_byte),
		.busy(busy),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.en(en),
		.cpol(cpol),
		.cpha(cpha),
		.div(div),
		.interrupt(interrupt)
	);

	spi_shifter i_spi_shifter (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.en(en),
		.cpha(cpha),
		.tx_valid(tx_valid),
		.tx_byte(tx_byte),
		.lead_edge(lead_edge),
		.trail_edge(trail_edge),
		.miso_bit(miso_bit),
		.tx_take(tx_take),
		.rx_strobe(rx_strobe),
		.rx_byte(rx_byte),
		.busy(busy),
		.run(run),
		.mosi_bit(mosi_bit),
		.ss_active(ss_active)
	);

	spi_serial_port i_spi_serial_port (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.en(en),
		.cpol(cpol),
		.div(div),
		.run(run),
		.mosi_bit(mosi_bit),
		.ss_active(ss_active),
		.miso(miso),
		.lead_edge(lead_edge),
		.trail_edge(trail_edge),
		.miso_bit(miso_bit),
		.sck(sck),
		.mosi(mosi),
		.ss_n(ss_n)
	);

endmodule

// ==== sim/spi_slave_model.sv ====
`timescale 1ns/100ps

module spi_slave_model (
	input logic sck,
	input logic mosi,
	input logic ss_n,
	input logic cpol,
	input logic cpha,
	input logic [7:0] reply,
	output logic miso,
	output logic [7:0] rx_byte,
	output logic [7:0] rx_prev,
	output logic [7:0] byte_cnt
);

	logic samp_clk;
	logic [7:0] in_sh = '0;
	logic [2:0] in_cnt = '0;
	logic [7:0] out_sh = '0;
	logic [2:0] out_cnt = '0;
	logic miso_q = 1'b0;
	logic [7:0] got_last = '0;
	logic [7:0] got_prev = '0;
	logic [7:0] got_cnt = '0;

	// rises on the sample edge in every mode.
	assign samp_clk = sck ^ cpol ^ cpha;

	// mode 0/2 shows the msb as soon as the byte starts.
	assign miso = cpha ? miso_q : ((out_cnt == 3'd0) ? reply[7] : out_sh[7]);
	assign rx_byte = got_last;
	assign rx_prev = got_prev;
	assign byte_cnt = got_cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive side.
	always @(posedge samp_clk or posedge ss_n) begin
		if (ss_n) begin
			in_cnt <= '0; // deselect realigns the byte.
		end else begin
			in_sh <= {in_sh[6:0], mosi};
			in_cnt <= in_cnt + 3'd1;
			if (in_cnt == 3'd7) begin
				got_prev <= got_last;
				got_last <= {in_sh[6:0], mosi};
				got_cnt <= got_cnt + 8'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// transmit side, msb first.
	always @(negedge samp_clk or posedge ss_n) begin
		if (ss_n) begin
			out_cnt <= '0;
		end else begin
			if (out_cnt == 3'd0) begin
				miso_q <= reply[7]; // first leading edge in mode 1/3.
				out_sh <= {reply[6:0], 1'b0};
			end else begin
				miso_q <= out_sh[7];
				out_sh <= {out_sh[6:0], 1'b0};
			end
			out_cnt <= out_cnt + 3'd1; // wraps for the next byte.
		end
	end

endmodule

// ==== sim/tb_spi_master.sv ====
`timescale 1ns/100ps
`include "spi_defines.svh"

module tb_spi_master;
	import spi_pkg::*;

	localparam int HALF_MAX = 1 << (1 << `SPI_DIV_W); // half period at div 7.
	localparam int XFER_MAX = 16 * HALF_MAX + 40;
	localparam int N_XFERS = 13;
	localparam int N_ACCESS = 64; // bus accesses outside transfers.
	localparam int TIMEOUT = 2 * (N_XFERS * XFER_MAX + N_ACCESS * 3);

	logic sys;
	logic n_sh_reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	spi_addr_t wb_adr;
	spi_data_t wb_dat_w;
	spi_data_t wb_dat_r;
	logic wb_ack;
	logic interrupt;
	logic miso;
	logic sck;
	logic mosi;
	logic ss_n;

	// slave model setup and results.
	logic m_cpol;
	logic m_cpha;
	spi_data_t m_reply;
	spi_data_t m_rx_byte;
	spi_data_t m_rx_prev;
	spi_data_t m_byte_cnt;

	logic [31:0] lfsr;
	int cycles = 0;
	spi_data_t ss_rises = '0;

	spi_master i_spi_master (
		.sys(sys),
		.n_sh_reset(n_sh_reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.interrupt(interrupt),
		.miso(miso),
		.sck(sck),
		.mosi(mosi),
		.ss_n(ss_n)
	);

	spi_slave_model i_spi_slave_model (
		.sck(sck),
		.mosi(mosi),
		.ss_n(ss_n),
		.cpol(m_cpol),
		.cpha(m_cpha),
		.reply(m_reply),
		.miso(miso),
		.rx_byte(m_rx_byte),
		.rx_prev(m_rx_prev),
		.byte_cnt(m_byte_cnt)
	);

	always #2 sys = ~sys;

	always @(posedge ss_n) ss_rises <= ss_rises + 8'd1;

	always @(posedge sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: tests still running after %0d cycles", cycles);
			abort_run();
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	task automatic abort_run();
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input spi_data_t got, input spi_data_t exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
			abort_run();
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic rand_byte(output spi_data_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	function automatic spi_data_t ctrl_val(input logic en, input logic cpol, input logic cpha,
			input logic ie, input spi_div_t div);
		spi_data_t v;
		v = '0;
		v[`SPI_CTRL_EN] = en;
		v[`SPI_CTRL_CPOL] = cpol;
		v[`SPI_CTRL_CPHA] = cpha;
		v[`SPI_CTRL_IE] = ie;
		v[`SPI_DIV_W-1:0] = div;
		return v;
	endfunction

	function automatic spi_data_t stat_val(input logic txe, input logic rxne, input logic busy);
		spi_data_t v;
		v = '0;
		v[`SPI_STAT_TXE] = txe;
		v[`SPI_STAT_RXNE] = rxne;
		v[`SPI_STAT_BUSY] = busy;
		return v;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// wishbone access.
	task automatic wait_ack();
		@(posedge sys);
		#1;
		while (!wb_ack) begin
			@(posedge sys);
			#1;
		end
	endtask

	task automatic wb_write(input spi_addr_t adr, input spi_data_t dat);
		@(posedge sys);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_w = dat;
		wait_ack();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input spi_addr_t adr, output spi_data_t dat);
		@(posedge sys);
		#1;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		wait_ack();
		dat = wb_dat_r; // valid with the ack.
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic wait_idle(output spi_data_t st);
		wb_read(`SPI_ADDR_STAT, st);
		while (st[`SPI_STAT_BUSY])
			wb_read(`SPI_ADDR_STAT, st);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	task automatic test_reset_state();
		spi_data_t got;
		wb_read(`SPI_ADDR_STAT, got);
		check_eq("status", got, stat_val(1'b1, 1'b0, 1'b0));
		wb_read(`SPI_ADDR_CTRL, got);
		check_eq("ctrl", got, 8'h00);
		check_bit("ss_n", ss_n, 1'b1);
		check_bit("sck", sck, 1'b0);
		check_bit("mosi", mosi, 1'b0);
		check_bit("interrupt", interrupt, 1'b0);
	endtask

	task automatic test_ctrl_rw();
		spi_data_t val;
		spi_data_t got;
		spi_data_t exp;
		for (int i = 0; i < 4; i++) begin
			if (i == 0)
				val = 8'h4f; // cpol and the reserved bit set.
			else
				rand_byte(val);
			val[`SPI_CTRL_EN] = 1'b0; // no transfer may start.
			exp = val;
			exp[`SPI_CTRL_RSVD] = 1'b0;
			wb_write(`SPI_ADDR_CTRL, val);
			wb_read(`SPI_ADDR_CTRL, got);
			check_eq("ctrl", got, exp);
			check_bit("sck", sck, val[`SPI_CTRL_CPOL]);
		end
		wb_write(`SPI_ADDR_CTRL, 8'h00);
		wb_read(`SPI_ADDR_CTRL, got);
		check_eq("ctrl", got, 8'h00);
		check_bit("sck", sck, 1'b0);
	endtask

	task automatic one_transfer(input logic cpol, input logic cpha, input spi_div_t div);
		spi_data_t tx;
		spi_data_t rep;
		spi_data_t st;
		spi_data_t got;
		spi_data_t cnt0;
		rand_byte(tx);
		rand_byte(rep);
		m_cpol = cpol;
		m_cpha = cpha;
		m_reply = rep;
		wb_write(`SPI_ADDR_CTRL, ctrl_val(1'b1, cpol, cpha, 1'b0, div));
		cnt0 = m_byte_cnt;
		wb_write(`SPI_ADDR_DATA, tx);
		wait_idle(st);
		check_eq("status", st, stat_val(1'b1, 1'b1, 1'b0));
		check_bit("ss_n", ss_n, 1'b1);
		check_bit("sck", sck, cpol);
		check_eq("slave byte count", m_byte_cnt, cnt0 + 8'd1);
		check_eq("slave rx byte", m_rx_byte, tx);
		wb_read(`SPI_ADDR_DATA, got);
		check_eq("data", got, rep);
		wb_read(`SPI_ADDR_STAT, st);
		check_eq("status", st, stat_val(1'b1, 1'b0, 1'b0));
	endtask

	task automatic test_modes();
		for (int m = 0; m < 4; m++) begin
			one_transfer(m[1], m[0], 3'd0);
			one_transfer(m[1], m[0], 3'd2);
		end
	endtask

	task automatic test_back_to_back();
		spi_data_t first;
		spi_data_t second;
		spi_data_t rep;
		spi_data_t st;
		spi_data_t got;
		spi_data_t cnt0;
		spi_data_t rises0;
		rand_byte(first);
		rand_byte(second);
		rand_byte(rep);
		m_cpol = 1'b0;
		m_cpha = 1'b0;
		m_reply = rep;
		wb_write(`SPI_ADDR_CTRL, ctrl_val(1'b1, 1'b0, 1'b0, 1'b0, 3'd2));
		cnt0 = m_byte_cnt;
		rises0 = ss_rises;
		wb_write(`SPI_ADDR_DATA, first);
		wb_write(`SPI_ADDR_DATA, second);
		wb_read(`SPI_ADDR_STAT, st);
		check_eq("status", st, stat_val(1'b0, 1'b0, 1'b1)); // second byte waits.
		wait_idle(st);
		check_eq("status", st, stat_val(1'b1, 1'b1, 1'b0));
		check_eq("slave byte count", m_byte_cnt, cnt0 + 8'd2);
		check_eq("slave first byte", m_rx_prev, first);
		check_eq("slave second byte", m_rx_byte, second);
		check_eq("ss_n rises", ss_rises, rises0 + 8'd1);
		wb_read(`SPI_ADDR_DATA, got);
		check_eq("data", got, rep);
	endtask

	task automatic test_interrupt();
		spi_data_t tx;
		spi_data_t st;
		spi_data_t got;
		rand_byte(tx);
		rand_byte(m_reply);
		m_cpol = 1'b0;
		m_cpha = 1'b0;
		wb_write(`SPI_ADDR_CTRL, ctrl_val(1'b1, 1'b0, 1'b0, 1'b1, 3'd0));
		wb_write(`SPI_ADDR_DATA, tx);
		check_bit("interrupt", interrupt, 1'b0);
		wait_idle(st);
		check_bit("interrupt", interrupt, 1'b1);
		wb_read(`SPI_ADDR_DATA, got);
		check_eq("data", got, m_reply);
		@(posedge sys); // interrupt lags RXNE by one cycle.
		#1;
		check_bit("interrupt", interrupt, 1'b0);
		// same transfer with IE clear.
		rand_byte(tx);
		wb_write(`SPI_ADDR_CTRL, ctrl_val(1'b1, 1'b0, 1'b0, 1'b0, 3'd0));
		wb_write(`SPI_ADDR_DATA, tx);
		wait_idle(st);
		check_eq("status", st, stat_val(1'b1, 1'b1, 1'b0));
		check_bit("interrupt", interrupt, 1'b0);
		wb_read(`SPI_ADDR_DATA, got);
	endtask

	task automatic test_disable();
		spi_data_t tx;
		spi_data_t tx2;
		spi_data_t st;
		rand_byte(tx);
		rand_byte(tx2);
		m_cpol = 1'b0;
		m_cpha = 1'b1;
		wb_write(`SPI_ADDR_CTRL, ctrl_val(1'b1, 1'b0, 1'b1, 1'b0, 3'd2));
		wb_write(`SPI_ADDR_DATA, tx);
		while (ss_n) begin
			@(posedge sys);
			#1;
		end
		wb_write(`SPI_ADDR_DATA, tx2); // waits behind the shifting byte.
		@(negedge sck); // first trailing edge in mid byte.
		wb_write(`SPI_ADDR_CTRL, ctrl_val(1'b0, 1'b0, 1'b1, 1'b0, 3'd2));
		wb_read(`SPI_ADDR_STAT, st);
		check_eq("status", st, stat_val(1'b1, 1'b0, 1'b0));
		check_bit("ss_n", ss_n, 1'b1);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		sys = 1'b0;
		n_sh_reset = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		m_cpol = 1'b0;
		m_cpha = 1'b0;
		m_reply = '0;
		lfsr = 32'h145c;
		repeat (3) @(posedge sys);
		#1;
		n_sh_reset = 1'b1;
		test_reset_state();
		test_ctrl_rw();
		test_modes();
		test_back_to_back();
		test_interrupt();
		test_disable();
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+design
design/spi_pkg.sv
design/spi_wb_regs.sv
design/spi_shifter.sv
design/spi_serial_port.sv
design/spi_master.sv
sim/spi_slave_model.sv
sim/tb_spi_master.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_spi_master
FILELIST = all.f
OBJ_DIR = obj_dir
SIM = $(OBJ_DIR)/V$(TOP)
PASS_MSG = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the status comes from grep, so a missing pass line fails the target.
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
